// ==== common/gpio_params.svh ====
// Address map, bank geometry and access wait counts of the GPIO slave
`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

////////////////////////////////////////////////////////////
// Data path geometry
////////////////////////////////////////////////////////////

// Bus word and GPIO word width
`define GPIO_DATA_W 32

// Words in each of the GPO and GPI banks
`define GPIO_WORDS 8

// Full pin width of one bank
`define GPIO_BANK_W 256

////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////

// Page of the slave, only the upper 24 bits select it
`define GPIO_BASE_ADDR 32'h0100_0000

// GPI bank starts here, GPO bank sits at offset zero
`define GPIO_GPI_OFFSET 32'h0000_0020

// Counting cycles before an access completes
`define GPIO_WRITE_WAIT 2
`define GPIO_READ_WAIT 3

`endif

// ==== common/gpio_pkg.sv ====
// Shared data word, word index and address view types of the GPIO slave
`default_nettype none

`include "gpio_params.svh"

package gpio_pkg;

	////////////////////////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////////////////////////

	// One bus or GPIO data word
	typedef logic [`GPIO_DATA_W-1:0] gpio_word_t;

	// Word index inside one bank
	typedef logic [$clog2(`GPIO_WORDS)-1:0] gpio_idx_t;

	////////////////////////////////////////////////////////////
	// Address view
	////////////////////////////////////////////////////////////

	// Field split of a slave address
	// Bit 5 picks the GPI bank, bits 4:2 the word
	typedef struct packed {
		logic [23:0] page;
		logic [1:0]  rsvd;
		logic        bank_sel;
		gpio_idx_t   word_idx;
		logic [1:0]  byte_off;
	} gpio_addr_fields_t;

	// Same address word seen whole or split into fields
	typedef union packed {
		gpio_word_t        raw;
		gpio_addr_fields_t fields;
	} gpio_addr_u;

endpackage : gpio_pkg

`default_nettype wire

// ==== rtl/bus_wait_counter.sv ====
// Access wait counter with the ready pulse of the GPIO slave
`timescale 1ns/10ps
`default_nettype none

`include "gpio_params.svh"

module bus_wait_counter
	import gpio_pkg::*;
(
	input  wire logic BUS_agnt_vi,
	input  wire logic reset,
	input  wire logic valid,
	input  wire logic rnw,
	output logic      access_done,
	output logic      ready
);

	// Wide enough for the longer of the two waits
	localparam int CNT_W = $clog2(`GPIO_READ_WAIT + 1);

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] target;

	////////////////////////////////////////////////////////////
	// Completion compare
	////////////////////////////////////////////////////////////

	// Reads wait one cycle longer than writes
	assign target = rnw ? CNT_W'(`GPIO_READ_WAIT) : CNT_W'(`GPIO_WRITE_WAIT);

	// Last counting cycle, commit happens on the next edge
	assign access_done = valid && (count == target);

	////////////////////////////////////////////////////////////
	// Count and ready register
	////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			count <= '0;
			ready <= 1'b0;
		end else begin
			// Ready lands on the same edge as the commit
			ready <= access_done;
			// Dropped valid abandons the access
			if (!valid || access_done) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Back to back accesses still leave a gap between ready pulses
	a_ready_single_pulse : assert property (
		@(posedge BUS_agnt_vi) disable iff (reset)
		ready |=> !ready
	);

endmodule : bus_wait_counter

`default_nettype wire

// ==== gpio_regs/gpio_access_decode.sv ====
// Address decode of the GPIO slave
// GPO and GPI read select, read_data and error registers, GPO write request
`timescale 1ns/10ps
`default_nettype none

`include "gpio_params.svh"

module gpio_access_decode
	import gpio_pkg::*;
(
	input  wire logic                    BUS_agnt_vi,
	input  wire logic                    reset,
	input  wire logic                    valid,
	input  wire logic                    rnw,
	input  wire logic                    access_done,
	input  wire gpio_word_t              addr,
	input  wire gpio_word_t              write_data,
	input  wire logic [`GPIO_BANK_W-1:0] gp_ip,
	input  wire gpio_word_t              gpo_rd_word,
	// Write request to the GPO bank
	output logic                         gpo_wr_en,
	output gpio_idx_t                    gpo_wr_idx,
	output gpio_word_t                   gpo_wr_data,
	// Bus response
	output gpio_word_t                   read_data,
	output logic                         error
);

	// Base address and the span of both banks within the page
	localparam gpio_word_t BASE_ADDR = `GPIO_BASE_ADDR;
	localparam logic [7:0] MAP_SPAN  = 8'(2 * `GPIO_GPI_OFFSET);

	gpio_addr_u addr_v;

	// Decode terms
	logic       page_hit;
	logic       in_window;
	logic       aligned;
	logic       slave_hit;
	logic       gpi_sel;
	logic       legal_wr;
	logic       legal_rd;
	gpio_word_t gpi_word;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	assign addr_v = addr;

	// Upper 24 bits must carry the slave page
	assign page_hit = (addr_v.fields.page == BASE_ADDR[31:8]);

	// Both banks together cover the low 64 bytes of the page
	// Covers the reserved bits 7:6 as well
	assign in_window = (addr_v.raw[7:0] < MAP_SPAN);

	// Word accesses only
	assign aligned = (addr_v.fields.byte_off == 2'b00);

	assign slave_hit = page_hit && in_window && aligned;

	// Upper half of the window is the GPI bank
	assign gpi_sel = addr_v.fields.bank_sel;

	// GPI is read only
	assign legal_wr = slave_hit && !gpi_sel;
	assign legal_rd = slave_hit;

	////////////////////////////////////////////////////////////
	// Read select
	////////////////////////////////////////////////////////////

	// Input word picked straight from the pins
	assign gpi_word = gp_ip[addr_v.fields.word_idx * `GPIO_DATA_W +: `GPIO_DATA_W];

	////////////////////////////////////////////////////////////
	// GPO write request
	////////////////////////////////////////////////////////////

	// Same index feeds the bank read-back mux
	assign gpo_wr_idx  = addr_v.fields.word_idx;
	assign gpo_wr_data = write_data;

	// Bank loads on the edge that raises ready
	assign gpo_wr_en = valid && access_done && !rnw && legal_wr;

	////////////////////////////////////////////////////////////
	// Response registers
	////////////////////////////////////////////////////////////

	// read_data holds until the next good read
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			read_data <= '0;
		end else if (access_done && rnw && legal_rd) begin
			read_data <= gpi_sel ? gpi_word : gpo_rd_word;
		end
	end

	// Error is only meaningful alongside ready
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			error <= 1'b0;
		end else if (!valid) begin
			error <= 1'b0;
		end else if (access_done) begin
			// Illegal write or read including misaligned ones
			error <= rnw ? !legal_rd : !legal_wr;
		end else begin
			error <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// A committed GPO write never answers with error
	a_wr_only_on_write : assert property (
		@(posedge BUS_agnt_vi) disable iff (reset)
		gpo_wr_en |=> !error
	);

endmodule : gpio_access_decode

`default_nettype wire

// ==== gpio_regs/gpo_reg_bank.sv ====
// GPO register bank of the GPIO slave
// Eight output words, one-cycle write strobes, combinational read-back
`timescale 1ns/10ps
`default_nettype none

`include "gpio_params.svh"

module gpo_reg_bank
	import gpio_pkg::*;
(
	input  wire logic               BUS_agnt_vi,
	input  wire logic               reset,
	// Write port from the decoder
	input  wire logic               gpo_wr_en,
	input  wire gpio_idx_t          gpo_wr_idx,
	input  wire gpio_word_t         gpo_wr_data,
	// Output pins
	output logic [`GPIO_BANK_W-1:0] gp_op,
	output logic [`GPIO_WORDS-1:0]  gp_op_valid,
	// Word at the current decoder index
	output gpio_word_t              gpo_rd_word
);

	// Output words with word 0 in the low bits of gp_op
	gpio_word_t gpo_words [`GPIO_WORDS];

	// Strobe pattern of the pending write
	logic [`GPIO_WORDS-1:0] wr_sel;

	////////////////////////////////////////////////////////////
	// Write select
	////////////////////////////////////////////////////////////

	always_comb begin
		wr_sel = '0;
		if (gpo_wr_en) begin
			wr_sel[gpo_wr_idx] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Word storage
	////////////////////////////////////////////////////////////

	// Indexed word load on a GPO write
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			for (int i = 0; i < `GPIO_WORDS; i++) begin
				gpo_words[i] <= '0;
			end
		end else if (gpo_wr_en) begin
			gpo_words[gpo_wr_idx] <= gpo_wr_data;
		end
	end

	// One-cycle strobe aligned with the word update
	always_ff @(posedge BUS_agnt_vi) begin
		if (reset) begin
			gp_op_valid <= '0;
		end else begin
			gp_op_valid <= wr_sel;
		end
	end

	////////////////////////////////////////////////////////////
	// Pin packing and read-back
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `GPIO_WORDS; g++) begin : g_pack
		assign gp_op[g * `GPIO_DATA_W +: `GPIO_DATA_W] = gpo_words[g];
	end

	// Read-back shares the write index
	assign gpo_rd_word = gpo_words[gpo_wr_idx];

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// At most one output word is strobed per cycle
	a_strobe_onehot : assert property (
		@(posedge BUS_agnt_vi) disable iff (reset)
		$onehot0(gp_op_valid)
	);

endmodule : gpo_reg_bank

`default_nettype wire

// ==== rtl/gpio_bus_slave.sv ====
// GPIO bus slave top level
// Joins the wait counter, address decoder and output register bank
`timescale 1ns/10ps
`default_nettype none

`include "gpio_params.svh"

module gpio_bus_slave
	import gpio_pkg::*;
(
	input  wire logic                    BUS_agnt_vi,
	input  wire logic                    reset,
	// Bus from the master
	input  wire logic                    valid,
	input  wire logic                    rnw,
	input  wire gpio_word_t              addr,
	input  wire gpio_word_t              write_data,
	// Bus response
	output logic                         ready,
	output logic                         error,
	output gpio_word_t                   read_data,
	// GPIO pins
	input  wire logic [`GPIO_BANK_W-1:0] gp_ip,
	output logic [`GPIO_BANK_W-1:0]      gp_op,
	output logic [`GPIO_WORDS-1:0]       gp_op_valid
);

	////////////////////////////////////////////////////////////
	// Internal wiring
	////////////////////////////////////////////////////////////

	// Final wait cycle of the current access
	logic access_done;

	// Write port and read-back word of the GPO bank
	logic       gpo_wr_en;
	gpio_idx_t  gpo_wr_idx;
	gpio_word_t gpo_wr_data;
	gpio_word_t gpo_rd_word;

	// Fixed wait per access type, gives ready
	bus_wait_counter i_bus_wait_counter (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.valid       (valid),
		.rnw         (rnw),
		.access_done (access_done),
		.ready       (ready)
	);

	// Address decode and response registers
	gpio_access_decode i_gpio_access_decode (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.valid       (valid),
		.rnw         (rnw),
		.access_done (access_done),
		.addr        (addr),
		.write_data  (write_data),
		.gp_ip       (gp_ip),
		.gpo_rd_word (gpo_rd_word),
		.gpo_wr_en   (gpo_wr_en),
		.gpo_wr_idx  (gpo_wr_idx),
		.gpo_wr_data (gpo_wr_data),
		.read_data   (read_data),
		.error       (error)
	);

	// Output words and their strobes
	gpo_reg_bank i_gpo_reg_bank (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.gpo_wr_en   (gpo_wr_en),
		.gpo_wr_idx  (gpo_wr_idx),
		.gpo_wr_data (gpo_wr_data),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid),
		.gpo_rd_word (gpo_rd_word)
	);

endmodule : gpio_bus_slave

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and synchronous reset source
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic BUS_agnt_vi,
	output logic reset
);

	// 20 ns period, first rising edge at 10 ns
	initial begin
		BUS_agnt_vi = 1'b0;
		forever #HALF_PERIOD BUS_agnt_vi = ~BUS_agnt_vi;
	end

	// Reset leaves on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge BUS_agnt_vi);
		@(negedge BUS_agnt_vi);
		reset = 1'b0;
	end

endmodule : tb_clock_gen

`default_nettype wire

// ==== verif/tb_bus_tasks.svh ====
// Address map rules, bus access with response checks and the directed tests
// Included into the testbench top
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// Cycles to wait for ready before the access counts as lost
localparam int ACCESS_LIMIT = 8;

////////////////////////////////////////////////////////////
// Address map rules
////////////////////////////////////////////////////////////

// Aligned word from 0x0100_0000 to 0x0100_001C
function automatic logic is_gpo(input gpio_word_t a);
	return (a >= `GPIO_BASE_ADDR) && (a <= `GPIO_BASE_ADDR + 32'h1C) && (a[1:0] == 2'b00);
endfunction

// Aligned word from 0x0100_0020 to 0x0100_003C
function automatic logic is_gpi(input gpio_word_t a);
	return (a >= `GPIO_BASE_ADDR + `GPIO_GPI_OFFSET) && (a <= `GPIO_BASE_ADDR + 32'h3C)
		&& (a[1:0] == 2'b00);
endfunction

// Word number inside whichever bank holds the address
function automatic int word_of(input gpio_word_t a);
	gpio_word_t off;
	off = a - `GPIO_BASE_ADDR;
	return int'((off % 32'h20) / 4);
endfunction

// Expected pin image, word 0 in the low bits
function automatic bank_t model_image();
	bank_t img;
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		img[i * `GPIO_DATA_W +: `GPIO_DATA_W] = gpo_model[i];
	end
	return img;
endfunction

task automatic report_mismatch(input string what, input bank_t got, input bank_t exp);
	mismatch_count++;
	$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
endtask

task automatic randomize_inputs();
	for (int k = 0; k < `GPIO_WORDS; k++) begin
		gp_ip[k * `GPIO_DATA_W +: `GPIO_DATA_W] = $urandom;
	end
endtask

////////////////////////////////////////////////////////////
// One bus access, checked at ready
////////////////////////////////////////////////////////////

task automatic bus_access(input logic is_read, input gpio_word_t a, input gpio_word_t wdata);
	int waited;
	int exp_wait;
	int w;
	logic exp_err;
	logic [`GPIO_WORDS-1:0] exp_strobe;
	// Write is ready 3 cycles after valid, read 4
	exp_wait = is_read ? 4 : 3;
	exp_err = is_read ? !(is_gpo(a) || is_gpi(a)) : !is_gpo(a);
	exp_strobe = '0;
	w = word_of(a);
	waited = 0;
	@(negedge BUS_agnt_vi);
	valid = 1'b1;
	rnw = is_read;
	addr = a;
	write_data = wdata;
	// No strobe may fire before ready
	do begin
		@(negedge BUS_agnt_vi);
		waited++;
		if (!ready && gp_op_valid !== '0)
			report_mismatch("strobe before ready", bank_t'(gp_op_valid), '0);
	end while (!ready && waited < ACCESS_LIMIT);
	if (!ready) begin
		failure_count++;
		$display("no ready within %0d cycles for access to %h", ACCESS_LIMIT, a);
	end else begin
		// Model commits on the ready edge, illegal accesses leave it alone
		if (!exp_err && !is_read) begin
			gpo_model[w] = wdata;
			exp_strobe[w] = 1'b1;
		end else if (!exp_err) begin
			last_read = is_gpi(a) ? gp_ip[w * `GPIO_DATA_W +: `GPIO_DATA_W] : gpo_model[w];
		end
		if (waited != exp_wait)
			report_mismatch("ready latency", bank_t'(waited), bank_t'(exp_wait));
		if (error !== exp_err)
			report_mismatch("error", bank_t'(error), bank_t'(exp_err));
		if (read_data !== last_read)
			report_mismatch("read_data", bank_t'(read_data), bank_t'(last_read));
		if (gp_op !== model_image())
			report_mismatch("gp_op", gp_op, model_image());
		if (gp_op_valid !== exp_strobe)
			report_mismatch("gp_op_valid", bank_t'(gp_op_valid), bank_t'(exp_strobe));
	end
	valid = 1'b0;
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic test_reset();
	if (ready !== 1'b0)
		report_mismatch("ready after reset", bank_t'(ready), '0);
	if (error !== 1'b0)
		report_mismatch("error after reset", bank_t'(error), '0);
	if (read_data !== '0)
		report_mismatch("read_data after reset", bank_t'(read_data), '0);
	if (gp_op !== '0)
		report_mismatch("gp_op after reset", gp_op, '0);
	if (gp_op_valid !== '0)
		report_mismatch("gp_op_valid after reset", bank_t'(gp_op_valid), '0);
endtask

task automatic test_gpo_writes();
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		bus_access(1'b0, `GPIO_BASE_ADDR + 32'(i * 4), $urandom);
	end
endtask

task automatic test_gpo_reads();
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		bus_access(1'b1, `GPIO_BASE_ADDR + 32'(i * 4), '0);
	end
endtask

// Fresh pin values before each input read
task automatic test_gpi_reads();
	for (int i = 0; i < `GPIO_WORDS; i++) begin
		randomize_inputs();
		bus_access(1'b1, `GPIO_BASE_ADDR + `GPIO_GPI_OFFSET + 32'(i * 4), '0);
	end
endtask

task automatic test_error_cases();
	// Writes into the read-only GPI bank
	bus_access(1'b0, `GPIO_BASE_ADDR + 32'h20, 32'hdead_beef);
	bus_access(1'b0, `GPIO_BASE_ADDR + 32'h3C, 32'h1234_5678);
	// Outside the map, reserved bits and foreign pages
	bus_access(1'b1, `GPIO_BASE_ADDR + 32'h40, '0);
	bus_access(1'b0, `GPIO_BASE_ADDR + 32'h80, 32'h0f0f_0f0f);
	bus_access(1'b1, 32'h0200_0004, '0);
	bus_access(1'b0, 32'h0000_0000, 32'hffff_ffff);
	// Not word aligned
	bus_access(1'b1, `GPIO_BASE_ADDR + 32'h01, '0);
	bus_access(1'b0, `GPIO_BASE_ADDR + 32'h06, 32'h5555_aaaa);
	bus_access(1'b1, `GPIO_BASE_ADDR + 32'h23, '0);
endtask

task automatic test_random(input int count);
	gpio_word_t rnd;
	repeat (count) begin
		randomize_inputs();
		rnd = $urandom;
		// Offsets up to 0x3F, misaligned ones included
		bus_access(rnd[31], `GPIO_BASE_ADDR | (rnd & 32'h3F), $urandom);
	end
endtask

`endif

// ==== verif/tb_gpio_bus_slave.sv ====
// Testbench top of the GPIO bus slave
// DUT, GPO reference model, error counters, timeout and final status
`timescale 1ns/10ps
`default_nettype none

`include "gpio_params.svh"

module tb_gpio_bus_slave
	import gpio_pkg::*;
();

	// About 95 accesses of at most 5 cycles each, plus reset, with wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	// Wide enough for any value shown on a mismatch line
	typedef logic [`GPIO_BANK_W-1:0] bank_t;

	logic                    BUS_agnt_vi;
	logic                    reset;
	logic                    valid;
	logic                    rnw;
	gpio_word_t              addr;
	gpio_word_t              write_data;
	logic                    ready;
	logic                    error;
	gpio_word_t              read_data;
	logic [`GPIO_BANK_W-1:0] gp_ip;
	logic [`GPIO_BANK_W-1:0] gp_op;
	logic [`GPIO_WORDS-1:0]  gp_op_valid;

	// Reference model of the GPO words and of the held read word
	gpio_word_t gpo_model [`GPIO_WORDS];
	gpio_word_t last_read;

	int mismatch_count;
	int failure_count;
	int cycle_count;

	tb_clock_gen i_tb_clock_gen (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset)
	);

	gpio_bus_slave i_gpio_bus_slave (
		.BUS_agnt_vi (BUS_agnt_vi),
		.reset       (reset),
		.valid       (valid),
		.rnw         (rnw),
		.addr        (addr),
		.write_data  (write_data),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.gp_ip       (gp_ip),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	`include "tb_bus_tasks.svh"

	////////////////////////////////////////////////////////////
	// Run limit
	////////////////////////////////////////////////////////////

	always @(posedge BUS_agnt_vi) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		// Bus idle and pins low from time zero
		valid = 1'b0;
		rnw = 1'b0;
		addr = '0;
		write_data = '0;
		gp_ip = '0;
		last_read = '0;
		mismatch_count = 0;
		failure_count = 0;
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			gpo_model[i] = '0;
		end
		void'($urandom(32'hc07d));
		// First falling edge after the DUT has seen reset low
		@(posedge BUS_agnt_vi);
		while (reset) begin
			@(posedge BUS_agnt_vi);
		end
		@(negedge BUS_agnt_vi);
		test_reset();
		test_gpo_writes();
		test_gpo_reads();
		test_gpi_reads();
		test_error_cases();
		test_random(60);
		$display("checks done: %0d mismatches, %0d other failures",
			mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : tb_gpio_bus_slave

`default_nettype wire

// ==== gpio_bus_slave.f ====
+incdir+common
+incdir+verif
common/gpio_pkg.sv
rtl/bus_wait_counter.sv
gpio_regs/gpio_access_decode.sv
gpio_regs/gpo_reg_bank.sv
rtl/gpio_bus_slave.sv
verif/tb_clock_gen.sv
verif/tb_gpio_bus_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the GPIO slave testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f gpio_bus_slave.f \
	--top-module tb_gpio_bus_slave

output=$(./obj_dir/Vtb_gpio_bus_slave 2>&1) || {
	echo "$output"
	echo "simulation exited with an error"
	exit 1
}
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
fi
echo "pass status not found in simulation output"
exit 1
